// ==== Makefile ====
SOURCES := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)

.PHONY: run clean

run: obj_dir/Vcp0Tb
	./obj_dir/Vcp0Tb | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

obj_dir/Vcp0Tb: $(SOURCES) filelist.f
	verilator --binary --timing --assert -Wno-fatal --top-module cp0Tb -f filelist.f

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
hdl/cp0ArchPkg.sv
hdl/cp0PipePkg.sv
hdl/cp0Interfaces.sv
hdl/exceptionArbiter.sv
hdl/cp0RegisterBank.sv
hdl/cp0Timer.sv
hdl/cp0Top.sv
testbench/clockGen.sv
testbench/cp0Tb.sv

// ==== hdl/cp0ArchPkg.sv ====
package cp0ArchPkg;

    // CP0 register numbers, select 0 only
    localparam logic [4:0] regBadVAddr = 5'd8;
    localparam logic [4:0] regCount    = 5'd9;
    localparam logic [4:0] regCompare  = 5'd11;
    localparam logic [4:0] regStatus   = 5'd12;
    localparam logic [4:0] regCause    = 5'd13;
    localparam logic [4:0] regEpc      = 5'd14;
    localparam logic [4:0] regPrId     = 5'd15;

    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excAdEL = 5'd4,   // Load or fetch address error
        excAdES = 5'd5,   // Store address error
        excSys  = 5'd8,
        excBp   = 5'd9,
        excRi   = 5'd10,  // Reserved instruction
        excCpU  = 5'd11,  // Coprocessor unusable
        excOv   = 5'd12,
        excTr   = 5'd13
    } excCode_t;

    // Status word in MIPS bit order, dead bits read zero
    typedef struct packed {
        logic [2:0] zero31;
        logic       cu0;     // Bit 28
        logic [4:0] zero27;
        logic       bev;     // Bit 22, bootstrap vectors
        logic [5:0] zero21;
        logic [7:0] im;      // Interrupt mask
        logic [2:0] zero7;
        logic       um;      // Bit 4, user mode
        logic [1:0] zero3;
        logic       exl;     // Exception level
        logic       ie;      // Global interrupt enable
    } statusFields_t;

    typedef struct packed {
        logic       bd;      // Branch delay slot
        logic [6:0] zero30;
        logic       iv;      // Special interrupt vector
        logic [6:0] zero22;
        logic [7:0] ip;      // Pending interrupts
        logic       zero7;
        excCode_t   excCode;
        logic [1:0] zero1;
    } causeFields_t;

    // MTC0 data seen as a raw word or through a register layout
    typedef union packed {
        logic [31:0]   raw;
        statusFields_t status;
        causeFields_t  cause;
    } cp0Word_u;

    localparam logic [31:0] vecResetBoot     = 32'hBFC0_0000;
    localparam logic [31:0] vecBaseBoot      = 32'hBFC0_0200;
    localparam logic [31:0] vecBaseNormal    = 32'h8000_0000;
    localparam logic [31:0] vecOffsetGeneral = 32'h0000_0180;
    localparam logic [31:0] vecOffsetSpecial = 32'h0000_0200;

    localparam logic [31:0] prIdValue = 32'h0000_0001;  // Revision 1

endpackage

// ==== hdl/cp0Interfaces.sv ====
`timescale 1ns/10ps

// Exception commit from the arbiter into the register bank
interface excCommitIf;
    logic                             commit;       // One cycle per taken exception
    cp0PipePkg::excStage_t            stage;
    cp0ArchPkg::excCode_t             code;
    logic [cp0PipePkg::dataWidth-1:0] restartPc;
    logic                             isBd;
    logic [cp0PipePkg::dataWidth-1:0] badAddr;
    logic                             loadBadAddr;  // MEM address error only
    logic                             eretCommit;

    modport arbiter (output commit, stage, code, restartPc, isBd, badAddr, loadBadAddr,
                     eretCommit);
    modport bank    (input  commit, stage, code, restartPc, isBd, badAddr, loadBadAddr,
                     eretCommit);
endinterface

// Architectural state the arbiter needs for masking and vectors
interface cp0StateIf;
    logic                             kernelMode;
    logic                             cu0;
    logic                             ie;
    logic                             exl;
    logic                             bev;
    logic                             iv;
    logic [7:0]                       im;
    logic [7:0]                       ip;
    logic [cp0PipePkg::dataWidth-1:0] epc;

    modport owner    (output kernelMode, cu0, ie, exl, bev, iv, im, ip, epc);
    modport observer (input  kernelMode, cu0, ie, exl, bev, iv, im, ip, epc);
endinterface

// ==== hdl/cp0PipePkg.sv ====
package cp0PipePkg;

    localparam int dataWidth = 32;

    // Pipeline stage that owns the exception being taken
    typedef enum logic [1:0] {
        stageNone = 2'd0,
        stageId   = 2'd1,
        stageEx   = 2'd2,
        stageMem  = 2'd3
    } excStage_t;

endpackage

// ==== hdl/cp0RegisterBank.sv ====
`timescale 1ns/10ps

module cp0RegisterBank #(
    parameter logic resetBev = 1'b1
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             mfc0,
    input  logic                             mtc0,
    input  logic [4:0]                       rd,
    input  logic [2:0]                       sel,
    input  cp0ArchPkg::cp0Word_u             regIn,
    input  logic                             idStall,
    input  logic [4:0]                       hwInt,
    output logic [cp0PipePkg::dataWidth-1:0] regOut,
    output logic                             kernelMode,
    output logic [7:0]                       pendingInt,
    input  logic                             timerPending,
    input  logic [cp0PipePkg::dataWidth-1:0] countValue,
    input  logic [cp0PipePkg::dataWidth-1:0] compareValue,
    output logic                             countWrite,
    output logic                             compareWrite,
    output logic                             countRead,     // Clears the timer interrupt
    excCommitIf.bank                         excCommit,
    cp0StateIf.owner                         cp0State
);
    cp0ArchPkg::statusFields_t statusReg;
    cp0ArchPkg::causeFields_t  causeReg;
    cp0ArchPkg::causeFields_t  causeView;  // Cause with the live timer bit
    logic [cp0PipePkg::dataWidth-1:0] epcReg;
    logic [cp0PipePkg::dataWidth-1:0] badVAddrReg;
    logic cp0Usable;
    logic selZero;
    logic regWrite;

    assign kernelMode = ~statusReg.um | statusReg.exl;
    assign cp0Usable  = statusReg.cu0 | kernelMode;
    assign selZero    = (sel == 3'd0);

    // An exception in any stage flushes the MTC0 in ID
    assign regWrite     = mtc0 & ~idStall & cp0Usable & selZero & ~excCommit.commit;
    assign countWrite   = regWrite & (rd == cp0ArchPkg::regCount);
    assign compareWrite = regWrite & (rd == cp0ArchPkg::regCompare);
    assign countRead    = mfc0 & cp0Usable & selZero & (rd == cp0ArchPkg::regCount);

    always_comb begin
        causeView       = causeReg;
        causeView.ip[7] = timerPending;  // IP7 is the Count/Compare match
    end

    assign pendingInt = causeView.ip;

    assign cp0State.kernelMode = kernelMode;
    assign cp0State.cu0        = statusReg.cu0;
    assign cp0State.ie         = statusReg.ie;
    assign cp0State.exl        = statusReg.exl;
    assign cp0State.bev        = statusReg.bev;
    assign cp0State.iv         = causeReg.iv;
    assign cp0State.im         = statusReg.im;
    assign cp0State.ip         = causeView.ip;
    assign cp0State.epc        = epcReg;

    always_ff @(posedge clock) begin
        if (reset) begin
            statusReg     <= '0;        // Kernel mode, interrupts off
            statusReg.bev <= resetBev;
            causeReg      <= '0;
        end else begin
            causeReg.ip[6:2] <= hwInt;  // Hardware lines, one cycle late
            if (excCommit.commit) begin
                statusReg.exl    <= 1'b1;
                causeReg.excCode <= excCommit.code;
                if (!statusReg.exl)
                    causeReg.bd <= excCommit.isBd;  // Nested exceptions keep the first BD
            end else begin
                if (excCommit.eretCommit)
                    statusReg.exl <= 1'b0;
                if (regWrite && rd == cp0ArchPkg::regStatus) begin
                    statusReg.cu0 <= regIn.status.cu0;
                    statusReg.bev <= regIn.status.bev;
                    statusReg.im  <= regIn.status.im;
                    statusReg.um  <= regIn.status.um;
                    statusReg.exl <= regIn.status.exl;
                    statusReg.ie  <= regIn.status.ie;
                end
                if (regWrite && rd == cp0ArchPkg::regCause) begin
                    causeReg.iv      <= regIn.cause.iv;
                    causeReg.ip[1:0] <= regIn.cause.ip[1:0];  // Software interrupts
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (excCommit.commit) begin
            if (!statusReg.exl)
                epcReg <= excCommit.restartPc;
        end else if (regWrite && rd == cp0ArchPkg::regEpc) begin
            epcReg <= regIn.raw;
        end
    end

    always_ff @(posedge clock) begin
        if (excCommit.commit && excCommit.loadBadAddr)
            badVAddrReg <= excCommit.badAddr;  // Read only to software
    end

    // MFC0 read port
    always_comb begin
        regOut = '0;
        if (mfc0 && cp0Usable && selZero) begin
            case (rd)
                cp0ArchPkg::regBadVAddr: regOut = badVAddrReg;
                cp0ArchPkg::regCount:    regOut = countValue;
                cp0ArchPkg::regCompare:  regOut = compareValue;
                cp0ArchPkg::regStatus:   regOut = statusReg;
                cp0ArchPkg::regCause:    regOut = causeView;
                cp0ArchPkg::regEpc:      regOut = epcReg;
                cp0ArchPkg::regPrId:     regOut = cp0ArchPkg::prIdValue;
                default:                 regOut = '0;
            endcase
        end
    end

    // Every commit names the stage it comes from
    assert property (@(posedge clock) disable iff (reset)
        excCommit.commit |-> excCommit.stage != cp0PipePkg::stageNone);

    // Commit beats an MTC0 to Status in the same cycle
    assert property (@(posedge clock) disable iff (reset)
        excCommit.commit && mtc0 && rd == cp0ArchPkg::regStatus
            |=> statusReg.exl && $stable(statusReg.im) && $stable(statusReg.ie));

endmodule

// ==== hdl/cp0Timer.sv ====
`timescale 1ns/10ps

module cp0Timer (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [cp0PipePkg::dataWidth-1:0] regIn,
    input  logic                             countWrite,
    input  logic                             compareWrite,
    input  logic                             countRead,
    output logic [cp0PipePkg::dataWidth-1:0] countValue,
    output logic [cp0PipePkg::dataWidth-1:0] compareValue,
    output logic                             timerPending
);
    logic match;

    assign match = (countValue == compareValue);

    always_ff @(posedge clock) begin
        if (reset) begin
            countValue   <= '0;
            compareValue <= '0;
            timerPending <= 1'b0;
        end else begin
            if (countWrite)
                countValue <= regIn;
            else
                countValue <= match ? '0 : countValue + 1'b1;  // Wrap on Compare
            if (compareWrite)
                compareValue <= regIn;
            timerPending <= countRead ? 1'b0 : (timerPending | match);  // Sticky until read
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        $rose(timerPending) |-> $past(match));

endmodule

// ==== hdl/cp0Top.sv ====
`timescale 1ns/10ps

module cp0Top #(
    parameter logic resetBev = 1'b1
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        mfc0,
    input  logic        mtc0,
    input  logic        eret,
    input  logic        idStall,
    input  logic        ifStall,
    input  logic        idIsFlushed,
    input  logic        exCanErr,
    input  logic        mCanErr,
    input  logic [4:0]  rd,
    input  logic [4:0]  hwInt,
    input  logic [2:0]  sel,
    input  logic [31:0] regIn,
    input  logic [31:0] idRestartPc,
    input  logic [31:0] exRestartPc,
    input  logic [31:0] mRestartPc,
    input  logic [31:0] badAddrM,
    input  logic        excAdEL,
    input  logic        excAdES,
    input  logic        excTr,
    input  logic        excOv,
    input  logic        excSys,
    input  logic        excBp,
    input  logic        excRi,
    input  logic        idIsBd,
    input  logic        exIsBd,
    input  logic        mIsBd,
    output logic [31:0] regOut,
    output logic [31:0] excPcOut,
    output logic        kernelMode,
    output logic        excPcSel,
    output logic        idExceptionStall,
    output logic        exExceptionStall,
    output logic        mExceptionStall,
    output logic        ifExceptionFlush,
    output logic        idExceptionFlush,
    output logic        exExceptionFlush,
    output logic        mExceptionFlush,
    output logic [7:0]  pendingInt
);
    logic [cp0PipePkg::dataWidth-1:0] countValue;
    logic [cp0PipePkg::dataWidth-1:0] compareValue;
    logic timerPending;
    logic countWrite;
    logic compareWrite;
    logic countRead;

    excCommitIf excCommit ();
    cp0StateIf  cp0State ();

    exceptionArbiter #(.resetBev(resetBev)) arbiter (
        .clock, .reset,
        .excAdEL, .excAdES, .excTr, .excOv, .excSys, .excBp, .excRi,
        .mfc0, .mtc0, .eret, .idStall, .ifStall, .idIsFlushed, .exCanErr, .mCanErr,
        .idRestartPc, .exRestartPc, .mRestartPc, .idIsBd, .exIsBd, .mIsBd, .badAddrM,
        .idExceptionStall, .exExceptionStall, .mExceptionStall,
        .ifExceptionFlush, .idExceptionFlush, .exExceptionFlush, .mExceptionFlush,
        .excPcSel, .excPcOut,
        .excCommit(excCommit.arbiter),
        .cp0State(cp0State.observer)
    );

    cp0RegisterBank #(.resetBev(resetBev)) bank (
        .clock, .reset, .mfc0, .mtc0, .rd, .sel, .regIn, .idStall, .hwInt,
        .regOut, .kernelMode, .pendingInt,
        .timerPending, .countValue, .compareValue, .countWrite, .compareWrite, .countRead,
        .excCommit(excCommit.bank),
        .cp0State(cp0State.owner)
    );

    cp0Timer timer (
        .clock, .reset, .regIn, .countWrite, .compareWrite, .countRead,
        .countValue, .compareValue, .timerPending
    );

endmodule

// ==== hdl/exceptionArbiter.sv ====
`timescale 1ns/10ps

module exceptionArbiter #(
    parameter logic resetBev = 1'b1
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             excAdEL,
    input  logic                             excAdES,
    input  logic                             excTr,
    input  logic                             excOv,
    input  logic                             excSys,
    input  logic                             excBp,
    input  logic                             excRi,
    input  logic                             mfc0,
    input  logic                             mtc0,
    input  logic                             eret,
    input  logic                             idStall,
    input  logic                             ifStall,
    input  logic                             idIsFlushed,
    input  logic                             exCanErr,   // EX or MEM may still fault
    input  logic                             mCanErr,
    input  logic [cp0PipePkg::dataWidth-1:0] idRestartPc,
    input  logic [cp0PipePkg::dataWidth-1:0] exRestartPc,
    input  logic [cp0PipePkg::dataWidth-1:0] mRestartPc,
    input  logic                             idIsBd,
    input  logic                             exIsBd,
    input  logic                             mIsBd,
    input  logic [cp0PipePkg::dataWidth-1:0] badAddrM,
    output logic                             idExceptionStall,
    output logic                             exExceptionStall,
    output logic                             mExceptionStall,
    output logic                             ifExceptionFlush,
    output logic                             idExceptionFlush,
    output logic                             exExceptionFlush,
    output logic                             mExceptionFlush,
    output logic                             excPcSel,
    output logic [cp0PipePkg::dataWidth-1:0] excPcOut,
    excCommitIf.arbiter                      excCommit,
    cp0StateIf.observer                      cp0State
);
    logic cpuExc, intExc;
    logic mDetect, exDetect, idDetect;
    logic mMask, exMask, idMask;
    logic mReady, exReady, idReady;
    logic eretCommit;
    logic resetDelayed;
    logic [cp0PipePkg::dataWidth-1:0] vecBase;

    // CP0 instructions in user mode need CU0
    assign cpuExc = (mfc0 | mtc0 | eret) & ~(cp0State.cu0 | cp0State.kernelMode);
    assign intExc = cp0State.ie & ~cp0State.exl & ~idIsFlushed
                  & (|(cp0State.ip & cp0State.im));

    assign mDetect  = excAdEL | excAdES | excTr;
    assign exDetect = excOv;
    assign idDetect = excSys | excBp | excRi | cpuExc | intExc;

    // A stage waits while any older stage can still fault
    assign mMask  = ifStall;
    assign exMask = ifStall | mCanErr;
    assign idMask = ifStall | mCanErr | exCanErr;

    assign mExceptionStall  = mDetect & mMask;
    assign exExceptionStall = exDetect & exMask & ~mDetect;
    assign idExceptionStall = (idDetect | eret | mtc0) & idMask & ~(exDetect | mDetect);

    // Oldest detected stage wins
    assign mReady  = ~idStall & mDetect & ~mMask;
    assign exReady = ~idStall & exDetect & ~exMask & ~mDetect;
    assign idReady = ~idStall & idDetect & ~idMask & ~(exDetect | mDetect);
    assign eretCommit = eret & ~idStall & ~idMask & ~(idDetect | exDetect | mDetect);

    // A faulting stage flushes itself and every younger one
    assign mExceptionFlush  = mDetect;
    assign exExceptionFlush = mDetect | exDetect;
    assign idExceptionFlush = mDetect | exDetect | idDetect;
    assign ifExceptionFlush = idExceptionFlush | eretCommit | resetDelayed;

    always_ff @(posedge clock) begin
        resetDelayed <= reset;  // Flush fetch once reset lifts
    end

    assign excCommit.commit      = mReady | exReady | idReady;
    assign excCommit.eretCommit  = eretCommit;
    assign excCommit.badAddr     = badAddrM;
    assign excCommit.loadBadAddr = mReady & (excAdEL | excAdES);

    always_comb begin
        if (mReady) begin
            excCommit.stage     = cp0PipePkg::stageMem;
            excCommit.restartPc = mRestartPc;
            excCommit.isBd      = mIsBd;
        end else if (exReady) begin
            excCommit.stage     = cp0PipePkg::stageEx;
            excCommit.restartPc = exRestartPc;
            excCommit.isBd      = exIsBd;
        end else begin
            excCommit.stage     = idReady ? cp0PipePkg::stageId : cp0PipePkg::stageNone;
            excCommit.restartPc = idRestartPc;
            excCommit.isBd      = idIsBd;
        end
    end

    // Program order priority, interrupt last
    always_comb begin
        if      (excAdEL) excCommit.code = cp0ArchPkg::excAdEL;
        else if (excAdES) excCommit.code = cp0ArchPkg::excAdES;
        else if (excTr)   excCommit.code = cp0ArchPkg::excTr;
        else if (excOv)   excCommit.code = cp0ArchPkg::excOv;
        else if (excSys)  excCommit.code = cp0ArchPkg::excSys;
        else if (excBp)   excCommit.code = cp0ArchPkg::excBp;
        else if (excRi)   excCommit.code = cp0ArchPkg::excRi;
        else if (cpuExc)  excCommit.code = cp0ArchPkg::excCpU;
        else              excCommit.code = cp0ArchPkg::excInt;
    end

    assign vecBase  = cp0State.bev ? cp0ArchPkg::vecBaseBoot : cp0ArchPkg::vecBaseNormal;
    assign excPcSel = reset | eretCommit | excCommit.commit;

    always_comb begin
        if (reset)
            excPcOut = cp0ArchPkg::vecResetBoot;
        else if (eretCommit)
            excPcOut = cp0State.epc;
        else if (excCommit.code == cp0ArchPkg::excInt && cp0State.iv)
            excPcOut = vecBase + cp0ArchPkg::vecOffsetSpecial;  // Dedicated interrupt vector
        else
            excPcOut = vecBase + cp0ArchPkg::vecOffsetGeneral;
    end

    assert property (@(posedge clock) disable iff (reset)
        $onehot0({mReady, exReady, idReady, eretCommit}));

    // Bank comes out of reset with the BEV set here
    assert property (@(posedge clock) resetDelayed && !reset |-> cp0State.bev == resetBev);

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/10ps

module clockGen #(
    parameter int resetCycles = 8
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;  // 10 ns period
    end

    // Released just after a rising edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

// ==== testbench/cp0Tb.sv ====
`timescale 1ns/10ps

module cp0Tb;
    localparam logic [31:0] resetVec   = 32'hBFC0_0000;
    localparam logic [31:0] bootBase   = 32'hBFC0_0200;  // BEV set
    localparam logic [31:0] generalOff = 32'h0000_0180;
    // Status bits that hold state: CU0, BEV, IM, UM, EXL, IE
    localparam logic [31:0] statusLive = (32'h1 << 28) | (32'h1 << 22) | (32'hFF << 8)
                                       | (32'h1 << 4) | (32'h1 << 1) | 32'h1;

    logic        clock, reset;
    logic        mfc0, mtc0, eret, idStall, ifStall, idIsFlushed, exCanErr, mCanErr;
    logic [4:0]  rd, hwInt;
    logic [2:0]  sel;
    logic [31:0] regIn, idRestartPc, exRestartPc, mRestartPc, badAddrM;
    logic        excAdEL, excAdES, excTr, excOv, excSys, excBp, excRi;
    logic        idIsBd, exIsBd, mIsBd;
    logic [31:0] regOut, excPcOut;
    logic        kernelMode, excPcSel;
    logic        idExceptionStall, exExceptionStall, mExceptionStall;
    logic        ifExceptionFlush, idExceptionFlush, exExceptionFlush, mExceptionFlush;
    logic [7:0]  pendingInt;
    logic [31:0] savedEpc;  // EPC the ERET test expects

    clockGen clockSource (.clock, .reset);

    cp0Top #(.resetBev(1'b1)) UUT (.*);

    task automatic abortRun(input string why);
        $display("ERROR: %s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else reportMismatch(name, got, expected);
    endtask

    // Every task starts and ends 1 ns after a rising edge
    task automatic nextCycle();
        @(posedge clock);
        #1;
    endtask

    task automatic writeReg(input logic [4:0] number, input logic [31:0] value);
        mtc0  = 1'b1;
        rd    = number;
        sel   = 3'd0;
        regIn = value;
        nextCycle();
        mtc0  = 1'b0;
    endtask

    task automatic readReg(input logic [4:0] number, input logic [2:0] select,
                           output logic [31:0] value);
        mfc0 = 1'b1;
        rd   = number;
        sel  = select;
        #2;
        value = regOut;  // Read mux is combinational
        nextCycle();
        mfc0 = 1'b0;
        sel  = 3'd0;
    endtask

    task automatic testReset();
        int waited;
        @(posedge clock);
        #3;
        checkValue("excPcSel", excPcSel, 32'd1);
        checkValue("excPcOut", excPcOut, resetVec);
        waited = 0;
        do begin
            nextCycle();
            #2;
            waited++;
        end while (reset && waited < 20);
        if (reset)
            abortRun("reset still high after 20 cycles");
        checkValue("ifExceptionFlush", ifExceptionFlush, 32'd1);  // First cycle out of reset
        checkValue("excPcSel", excPcSel, 32'd0);
        checkValue("kernelMode", kernelMode, 32'd1);
        checkValue("stalls", {idExceptionStall, exExceptionStall, mExceptionStall}, 32'd0);
        nextCycle();
        #2;
        checkValue("ifExceptionFlush", ifExceptionFlush, 32'd0);
        nextCycle();
    endtask

    task automatic testRegisterAccess();
        logic [31:0] value;
        readReg(cp0ArchPkg::regStatus, 3'd0, value);
        checkValue("Status", value, 32'h0040_0000);  // Only BEV after reset
        writeReg(cp0ArchPkg::regEpc, 32'h1234_5678);
        writeReg(cp0ArchPkg::regCompare, 32'h0000_8000);
        writeReg(cp0ArchPkg::regStatus, 32'hFFFF_FFFF);
        readReg(cp0ArchPkg::regEpc, 3'd0, value);
        checkValue("EPC", value, 32'h1234_5678);
        readReg(cp0ArchPkg::regCompare, 3'd0, value);
        checkValue("Compare", value, 32'h0000_8000);
        readReg(cp0ArchPkg::regStatus, 3'd0, value);
        checkValue("Status", value, 32'hFFFF_FFFF & statusLive);
        writeReg(cp0ArchPkg::regStatus, 32'h0040_0000);  // Kernel, interrupts off
        readReg(cp0ArchPkg::regPrId, 3'd0, value);
        checkValue("PRId", value, 32'h0000_0001);
        readReg(5'd20, 3'd0, value);
        checkValue("reg20", value, 32'd0);
        readReg(cp0ArchPkg::regStatus, 3'd1, value);
        checkValue("Status sel1", value, 32'd0);
        // Count sat on Compare right after reset, so the timer bit is set
        checkValue("pendingInt[7]", pendingInt[7], 32'd1);
        readReg(cp0ArchPkg::regCount, 3'd0, value);
        #2;
        checkValue("pendingInt[7]", pendingInt[7], 32'd0);
        nextCycle();
    endtask

    task automatic testSyscall();
        logic [31:0] value;
        idRestartPc = 32'h0040_0100;
        excSys      = 1'b1;
        #2;
        checkValue("excPcSel", excPcSel, 32'd1);
        checkValue("idExceptionFlush", idExceptionFlush, 32'd1);
        checkValue("ifExceptionFlush", ifExceptionFlush, 32'd1);
        checkValue("excPcOut", excPcOut, bootBase + generalOff);
        nextCycle();
        excSys = 1'b0;
        readReg(cp0ArchPkg::regCause, 3'd0, value);
        checkValue("Cause.ExcCode", value[6:2], 32'd8);
        readReg(cp0ArchPkg::regEpc, 3'd0, value);
        checkValue("EPC", value, 32'h0040_0100);
        checkValue("kernelMode", kernelMode, 32'd1);
    endtask

    task automatic testPriority();
        logic [31:0] value;
        writeReg(cp0ArchPkg::regStatus, 32'h0040_0000);  // EXL clear so EPC loads
        mRestartPc = 32'h0040_0200;
        badAddrM   = 32'h0000_1003;
        excAdEL    = 1'b1;
        excSys     = 1'b1;  // Younger, must lose
        #2;
        checkValue("mExceptionFlush", mExceptionFlush, 32'd1);
        checkValue("exExceptionFlush", exExceptionFlush, 32'd1);
        checkValue("excPcSel", excPcSel, 32'd1);
        nextCycle();
        excAdEL = 1'b0;
        excSys  = 1'b0;
        readReg(cp0ArchPkg::regCause, 3'd0, value);
        checkValue("Cause.ExcCode", value[6:2], 32'd4);
        readReg(cp0ArchPkg::regEpc, 3'd0, value);
        checkValue("EPC", value, 32'h0040_0200);
        savedEpc = mRestartPc;
        readReg(cp0ArchPkg::regBadVAddr, 3'd0, value);
        checkValue("BadVAddr", value, 32'h0000_1003);
        // Sys waits while MEM may still fault
        excSys  = 1'b1;
        mCanErr = 1'b1;
        #2;
        checkValue("idExceptionStall", idExceptionStall, 32'd1);
        checkValue("excPcSel", excPcSel, 32'd0);
        nextCycle();
        excSys  = 1'b0;
        mCanErr = 1'b0;
        readReg(cp0ArchPkg::regCause, 3'd0, value);
        checkValue("Cause.ExcCode", value[6:2], 32'd4);  // Nothing committed
    endtask

    task automatic testEret();
        logic [31:0] value;
        eret = 1'b1;
        #2;
        checkValue("excPcSel", excPcSel, 32'd1);
        checkValue("excPcOut", excPcOut, savedEpc);
        checkValue("ifExceptionFlush", ifExceptionFlush, 32'd1);
        nextCycle();
        eret = 1'b0;
        readReg(cp0ArchPkg::regStatus, 3'd0, value);
        checkValue("Status.EXL", value[1], 32'd0);
    endtask

    task automatic testTimerInterrupt();
        logic [31:0] value;
        int          waited;
        writeReg(cp0ArchPkg::regCount, 32'd0);
        writeReg(cp0ArchPkg::regCompare, 32'd20);
        writeReg(cp0ArchPkg::regStatus, 32'h0040_8001);  // IM7, IE, BEV
        hwInt = 5'b10110;
        #2;
        checkValue("pendingInt[6:2]", pendingInt[6:2], 32'd0);  // Not sampled yet
        nextCycle();
        hwInt = 5'b00000;
        #2;
        checkValue("pendingInt[6:2]", pendingInt[6:2], 32'b10110);
        waited = 0;
        do begin
            nextCycle();
            #2;
            waited++;
        end while (!pendingInt[7] && waited < 100);
        if (!pendingInt[7])
            abortRun("timer interrupt not pending within 100 cycles");
        checkValue("excPcSel", excPcSel, 32'd1);
        checkValue("excPcOut", excPcOut, bootBase + generalOff);
        nextCycle();
        readReg(cp0ArchPkg::regCause, 3'd0, value);
        checkValue("Cause.ExcCode", value[6:2], 32'd0);
        readReg(cp0ArchPkg::regCount, 3'd0, value);
        #2;
        checkValue("pendingInt[7]", pendingInt[7], 32'd0);  // Read cleared it
        nextCycle();
    endtask

    task automatic testCopUnusable();
        logic [31:0] value;
        writeReg(cp0ArchPkg::regStatus, 32'h0040_0010);  // UM set, EXL clear
        #2;
        checkValue("kernelMode", kernelMode, 32'd0);
        nextCycle();
        mfc0 = 1'b1;
        rd   = cp0ArchPkg::regStatus;
        #2;
        checkValue("excPcSel", excPcSel, 32'd1);
        checkValue("regOut", regOut, 32'd0);  // No data in user mode
        nextCycle();
        mfc0 = 1'b0;
        #2;
        checkValue("kernelMode", kernelMode, 32'd1);
        nextCycle();
        readReg(cp0ArchPkg::regCause, 3'd0, value);
        checkValue("Cause.ExcCode", value[6:2], 32'd11);
    endtask

    initial begin
        savedEpc  = '0;
        {mfc0, mtc0, eret, idStall, ifStall, idIsFlushed, exCanErr, mCanErr} = '0;
        {excAdEL, excAdES, excTr, excOv, excSys, excBp, excRi} = '0;
        {idIsBd, exIsBd, mIsBd} = '0;
        rd          = '0;
        hwInt       = '0;
        sel         = '0;
        regIn       = '0;
        idRestartPc = '0;
        exRestartPc = '0;
        mRestartPc  = '0;
        badAddrM    = '0;
        testReset();
        testRegisterAccess();
        testSyscall();
        testPriority();
        testEret();
        testTimerInterrupt();
        testCopUnusable();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
